// ==== backend_defines.svh ====
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// datapath and address width
`define DATA_W      32

// architectural register count
`define REG_NUM     32

// redirect target for an illegal instruction
`define EXCP_ENTRY  32'h1c00_8000

// first fetch address after reset
`define RESET_PC    32'h1c00_0000

`endif

// ==== backend_pkg.sv ====
package backend_pkg;

    // alu operation selected by the decoder
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        // lu12i.w passes the shifted immediate through
        ALU_IMM = 3'd6
    } alu_op_t;

    // branch kind
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_BEQ    = 2'd1,
        BR_BNE    = 2'd2,
        BR_ALWAYS = 2'd3
    } br_op_t;

    // architectural register number
    typedef logic [4:0] reg_addr_t;

endpackage

// ==== inst_decoder.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module inst_decoder (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   inst_valid_i,
    input  logic [`DATA_W-1:0]     pc_i,
    input  logic [31:0]            inst_i,
    output logic                   d_valid_o,
    output logic [`DATA_W-1:0]     d_pc_o,
    output backend_pkg::alu_op_t   d_alu_op_o,
    output backend_pkg::br_op_t    d_br_op_o,
    output backend_pkg::reg_addr_t d_rd_o,
    output backend_pkg::reg_addr_t d_rj_o,
    output backend_pkg::reg_addr_t d_rk_o,
    output logic                   d_use_imm_o,
    output logic [`DATA_W-1:0]     d_imm_o,
    output logic                   d_wen_o,
    output logic                   d_illegal_o
);
    import backend_pkg::*;

    alu_op_t            alu_op;
    br_op_t             br_op;
    reg_addr_t          rd;
    reg_addr_t          rj;
    reg_addr_t          rk;
    logic               use_imm;
    logic [`DATA_W-1:0] imm;
    logic               wen;
    logic               illegal;

    logic [`DATA_W-1:0] si12_ext;
    logic [`DATA_W-1:0] si20_shl;
    logic [`DATA_W-1:0] offs16_ext;
    logic [`DATA_W-1:0] offs26_ext;

    assign si12_ext   = {{20{inst_i[21]}}, inst_i[21:10]};
    assign si20_shl   = {inst_i[24:5], 12'b0};
    assign offs16_ext = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    // offs26 is split, high part sits in [9:0]
    assign offs26_ext = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    always_comb begin
        alu_op  = ALU_ADD;
        br_op   = BR_NONE;
        rd      = inst_i[4:0];
        rj      = inst_i[9:5];
        rk      = inst_i[14:10];
        use_imm = 1'b0;
        imm     = si12_ext;
        wen     = 1'b0;
        illegal = 1'b0;
        casez (inst_i[31:15])
            17'b00000000000100000: begin
                alu_op = ALU_ADD;
                wen    = 1'b1;
            end
            17'b00000000000100010: begin
                alu_op = ALU_SUB;
                wen    = 1'b1;
            end
            17'b00000000000100100: begin
                alu_op = ALU_SLT;
                wen    = 1'b1;
            end
            17'b00000000000101001: begin
                alu_op = ALU_AND;
                wen    = 1'b1;
            end
            17'b00000000000101010: begin
                alu_op = ALU_OR;
                wen    = 1'b1;
            end
            17'b00000000000101011: begin
                alu_op = ALU_XOR;
                wen    = 1'b1;
            end
            17'b0000001010???????: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
                wen     = 1'b1;
            end
            17'b0001010??????????: begin
                alu_op  = ALU_IMM;
                use_imm = 1'b1;
                imm     = si20_shl;
                wen     = 1'b1;
            end
            // branches compare rj against the rd field
            17'b010110???????????: begin
                br_op = BR_BEQ;
                rk    = inst_i[4:0];
                rd    = '0;
                imm   = offs16_ext;
            end
            17'b010111???????????: begin
                br_op = BR_BNE;
                rk    = inst_i[4:0];
                rd    = '0;
                imm   = offs16_ext;
            end
            17'b010100???????????: begin
                br_op = BR_ALWAYS;
                rd    = '0;
                imm   = offs26_ext;
            end
            default: begin
                rd      = '0;
                illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            d_valid_o <= 1'b0;
        end else begin
            d_valid_o <= inst_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        d_pc_o      <= pc_i;
        d_alu_op_o  <= alu_op;
        d_br_op_o   <= br_op;
        d_rd_o      <= rd;
        d_rj_o      <= rj;
        d_rk_o      <= rk;
        d_use_imm_o <= use_imm;
        d_imm_o     <= imm;
        d_wen_o     <= wen;
        d_illegal_o <= illegal;
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_i,
    input  backend_pkg::reg_addr_t ra_i,
    input  backend_pkg::reg_addr_t rb_i,
    output logic [`DATA_W-1:0]     rdata_a_o,
    output logic [`DATA_W-1:0]     rdata_b_o,
    input  logic                   wen_i,
    input  backend_pkg::reg_addr_t waddr_i,
    input  logic [`DATA_W-1:0]     wdata_i
);

    logic [`DATA_W-1:0] regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 hardwired to zero
    assign rdata_a_o = (ra_i == '0) ? '0 : regs[ra_i];
    assign rdata_b_o = (rb_i == '0) ? '0 : regs[rb_i];

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   d_valid_i,
    input  logic [`DATA_W-1:0]     d_pc_i,
    input  backend_pkg::alu_op_t   d_alu_op_i,
    input  backend_pkg::br_op_t    d_br_op_i,
    input  backend_pkg::reg_addr_t d_rd_i,
    input  backend_pkg::reg_addr_t d_rj_i,
    input  backend_pkg::reg_addr_t d_rk_i,
    input  logic                   d_use_imm_i,
    input  logic [`DATA_W-1:0]     d_imm_i,
    input  logic                   d_wen_i,
    input  logic                   d_illegal_i,
    output backend_pkg::reg_addr_t ra_o,
    output backend_pkg::reg_addr_t rb_o,
    input  logic [`DATA_W-1:0]     rdata_a_i,
    input  logic [`DATA_W-1:0]     rdata_b_i,
    input  logic                   wb_en_i,
    input  backend_pkg::reg_addr_t wb_addr_i,
    input  logic [`DATA_W-1:0]     wb_data_i,
    output logic                   e_valid_o,
    output logic [`DATA_W-1:0]     e_pc_o,
    output backend_pkg::reg_addr_t e_rd_o,
    output logic                   e_wen_o,
    output logic [`DATA_W-1:0]     e_result_o,
    output logic                   e_redirect_o,
    output logic [`DATA_W-1:0]     e_target_o,
    output logic                   e_illegal_o
);
    import backend_pkg::*;

    logic               fwd_a;
    logic               fwd_b;
    logic [`DATA_W-1:0] src_a;
    logic [`DATA_W-1:0] src_b;
    logic [`DATA_W-1:0] opnd_b;
    logic [`DATA_W-1:0] alu_res;
    logic               taken;
    logic [`DATA_W-1:0] target;

    assign ra_o = d_rj_i;
    assign rb_o = d_rk_i;

    // bypass from the write in flight at commit
    assign fwd_a = wb_en_i && (wb_addr_i == d_rj_i) && (wb_addr_i != '0);
    assign fwd_b = wb_en_i && (wb_addr_i == d_rk_i) && (wb_addr_i != '0);
    assign src_a = fwd_a ? wb_data_i : rdata_a_i;
    assign src_b = fwd_b ? wb_data_i : rdata_b_i;

    assign opnd_b = d_use_imm_i ? d_imm_i : src_b;

    always_comb begin
        case (d_alu_op_i)
            ALU_ADD: alu_res = src_a + opnd_b;
            ALU_SUB: alu_res = src_a - opnd_b;
            ALU_AND: alu_res = src_a & opnd_b;
            ALU_OR:  alu_res = src_a | opnd_b;
            ALU_XOR: alu_res = src_a ^ opnd_b;
            ALU_SLT: alu_res = {{(`DATA_W-1){1'b0}}, $signed(src_a) < $signed(opnd_b)};
            ALU_IMM: alu_res = d_imm_i;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (d_br_op_i)
            BR_BEQ:    taken = (src_a == src_b);
            BR_BNE:    taken = (src_a != src_b);
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // offset already shifted by the decoder
    assign target = d_pc_i + d_imm_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            e_valid_o <= 1'b0;
        end else begin
            e_valid_o <= d_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        e_pc_o       <= d_pc_i;
        e_rd_o       <= d_rd_i;
        e_wen_o      <= d_wen_i;
        e_result_o   <= alu_res;
        e_redirect_o <= taken;
        e_target_o   <= target;
        e_illegal_o  <= d_illegal_i;
    end

endmodule

// ==== commit_ctrl.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module commit_ctrl (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   e_valid_i,
    input  logic [`DATA_W-1:0]     e_pc_i,
    input  backend_pkg::reg_addr_t e_rd_i,
    input  logic                   e_wen_i,
    input  logic [`DATA_W-1:0]     e_result_i,
    input  logic                   e_redirect_i,
    input  logic [`DATA_W-1:0]     e_target_i,
    input  logic                   e_illegal_i,
    output logic                   wb_en_o,
    output backend_pkg::reg_addr_t wb_addr_o,
    output logic [`DATA_W-1:0]     wb_data_o,
    output logic                   flush_o,
    output logic [`DATA_W-1:0]     new_pc_o,
    output logic                   commit_valid_o,
    output logic [`DATA_W-1:0]     commit_pc_o,
    output backend_pkg::reg_addr_t commit_rd_o,
    output logic [`DATA_W-1:0]     commit_data_o,
    output logic [31:0]            retire_cnt_o
);

    logic writes;

    // an illegal instruction never writes back
    assign writes = e_wen_i & ~e_illegal_i;

    assign wb_en_o   = e_valid_i & writes;
    assign wb_addr_o = e_rd_i;
    assign wb_data_o = e_result_i;

    assign flush_o  = e_valid_i & (e_redirect_i | e_illegal_i);
    assign new_pc_o = e_illegal_i ? `EXCP_ENTRY : e_target_i;

    // commit trace, non-writing instructions show rd and data as zero
    assign commit_valid_o = e_valid_i;
    assign commit_pc_o    = e_pc_i;
    assign commit_rd_o    = writes ? e_rd_i : '0;
    assign commit_data_o  = writes ? e_result_i : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_cnt_o <= '0;
        end else if (e_valid_i) begin
            retire_cnt_o <= retire_cnt_o + 32'd1;
        end
    end

endmodule

// ==== backend_top.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module backend_top (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   inst_valid_i,
    input  logic [`DATA_W-1:0]     pc_i,
    input  logic [31:0]            inst_i,
    output logic                   flush_o,
    output logic [`DATA_W-1:0]     new_pc_o,
    output logic                   commit_valid_o,
    output logic [`DATA_W-1:0]     commit_pc_o,
    output backend_pkg::reg_addr_t commit_rd_o,
    output logic [`DATA_W-1:0]     commit_data_o,
    output logic [31:0]            retire_cnt_o
);
    import backend_pkg::*;

    // decode stage
    logic               d_valid;
    logic [`DATA_W-1:0] d_pc;
    alu_op_t            d_alu_op;
    br_op_t             d_br_op;
    reg_addr_t          d_rd;
    reg_addr_t          d_rj;
    reg_addr_t          d_rk_or_rd;
    logic               d_use_imm;
    logic [`DATA_W-1:0] d_imm;
    logic               d_wen;
    logic               d_illegal;

    // register file read
    reg_addr_t          ra;
    reg_addr_t          rb;
    logic [`DATA_W-1:0] rdata_a;
    logic [`DATA_W-1:0] rdata_b;

    // execute stage
    logic               e_valid;
    logic [`DATA_W-1:0] e_pc;
    reg_addr_t          e_rd;
    logic               e_wen;
    logic [`DATA_W-1:0] e_result;
    logic               e_redirect;
    logic [`DATA_W-1:0] e_target;
    logic               e_illegal;

    // writeback, also the bypass source
    logic               wb_en;
    reg_addr_t          wb_addr;
    logic [`DATA_W-1:0] wb_data;

    inst_decoder u_decoder (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_o),
        .inst_valid_i (inst_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .d_valid_o    (d_valid),
        .d_pc_o       (d_pc),
        .d_alu_op_o   (d_alu_op),
        .d_br_op_o    (d_br_op),
        .d_rd_o       (d_rd),
        .d_rj_o       (d_rj),
        .d_rk_o       (d_rk_or_rd),
        .d_use_imm_o  (d_use_imm),
        .d_imm_o      (d_imm),
        .d_wen_o      (d_wen),
        .d_illegal_o  (d_illegal)
    );

    reg_file u_regfile (
        .clk       (clk),
        .rst_i     (rst_i),
        .ra_i      (ra),
        .rb_i      (rb),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wen_i     (wb_en),
        .waddr_i   (wb_addr),
        .wdata_i   (wb_data)
    );

    exec_unit u_exec (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_o),
        .d_valid_i    (d_valid),
        .d_pc_i       (d_pc),
        .d_alu_op_i   (d_alu_op),
        .d_br_op_i    (d_br_op),
        .d_rd_i       (d_rd),
        .d_rj_i       (d_rj),
        .d_rk_i       (d_rk_or_rd),
        .d_use_imm_i  (d_use_imm),
        .d_imm_i      (d_imm),
        .d_wen_i      (d_wen),
        .d_illegal_i  (d_illegal),
        .ra_o         (ra),
        .rb_o         (rb),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .wb_en_i      (wb_en),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_data),
        .e_valid_o    (e_valid),
        .e_pc_o       (e_pc),
        .e_rd_o       (e_rd),
        .e_wen_o      (e_wen),
        .e_result_o   (e_result),
        .e_redirect_o (e_redirect),
        .e_target_o   (e_target),
        .e_illegal_o  (e_illegal)
    );

    commit_ctrl u_commit (
        .clk            (clk),
        .rst_i          (rst_i),
        .e_valid_i      (e_valid),
        .e_pc_i         (e_pc),
        .e_rd_i         (e_rd),
        .e_wen_i        (e_wen),
        .e_result_i     (e_result),
        .e_redirect_i   (e_redirect),
        .e_target_i     (e_target),
        .e_illegal_i    (e_illegal),
        .wb_en_o        (wb_en),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data),
        .flush_o        (flush_o),
        .new_pc_o       (new_pc_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .retire_cnt_o   (retire_cnt_o)
    );

endmodule

// ==== backend_assert.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module backend_assert (
    input logic               clk,
    input logic               rst_i,
    input logic               flush_i,
    input logic [`DATA_W-1:0] new_pc_i,
    input logic               commit_valid_i
);

    // only a committing instruction can redirect
    property flush_with_commit;
        @(posedge clk) disable iff (rst_i) flush_i |-> commit_valid_i;
    endproperty

    // the wrong-path slot behind a flush is already killed
    property single_cycle_flush;
        @(posedge clk) disable iff (rst_i) flush_i |=> !flush_i;
    endproperty

    property aligned_redirect;
        @(posedge clk) disable iff (rst_i) flush_i |-> (new_pc_i[1:0] == 2'b00);
    endproperty

    // stage valids are cleared by the first reset edge
    property quiet_in_reset;
        @(posedge clk) rst_i |=> !commit_valid_i;
    endproperty

    flush_with_commit_a: assert property (flush_with_commit)
        else $error("flush raised without a commit");
    single_cycle_flush_a: assert property (single_cycle_flush)
        else $error("flush held for two cycles");
    aligned_redirect_a: assert property (aligned_redirect)
        else $error("redirect target not word aligned");
    quiet_in_reset_a: assert property (quiet_in_reset)
        else $error("commit valid during reset");

endmodule

bind backend_top backend_assert u_assert (
    .clk            (clk),
    .rst_i          (rst_i),
    .flush_i        (flush_o),
    .new_pc_i       (new_pc_o),
    .commit_valid_i (commit_valid_o)
);

// ==== backend_tb.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module backend_tb;

    logic                   clk;
    logic                   rst_i;
    logic                   inst_valid_i;
    logic [`DATA_W-1:0]     pc_i;
    logic [31:0]            inst_i;
    logic                   flush_o;
    logic [`DATA_W-1:0]     new_pc_o;
    logic                   commit_valid_o;
    logic [`DATA_W-1:0]     commit_pc_o;
    backend_pkg::reg_addr_t commit_rd_o;
    logic [`DATA_W-1:0]     commit_data_o;
    logic [31:0]            retire_cnt_o;

    // flat image of backend_golden.txt
    logic [31:0] golden [256];
    string       test_names [6] = '{"alu", "bypass", "r0", "branch", "illegal", "retire"};

    int                 prog_n;
    int                 trace_n;
    int                 trace_base;
    int                 trace_idx;
    int                 cur_test;
    int                 cycles;
    int                 cycle_limit;
    int                 errors;
    int                 test_checks;
    int                 test_errors;
    int                 tests_done;
    int                 tests_failed;
    logic [`DATA_W-1:0] fetch_pc;
    logic               front_flush;
    logic [`DATA_W-1:0] front_new_pc;

    backend_top dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .pc_i           (pc_i),
        .inst_i         (inst_i),
        .flush_o        (flush_o),
        .new_pc_o       (new_pc_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .retire_cnt_o   (retire_cnt_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // index of the program entry at addr or -1 outside the image
    function automatic int find_inst(input logic [`DATA_W-1:0] addr);
        int found;
        found = -1;
        for (int i = 0; i < prog_n; i++) begin
            if (golden[1 + 2 * i] == addr) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic report_mismatch(input int id, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERROR %s %s: expected %08h, actual %08h",
                 test_names[id], field, expected, actual);
        test_errors++;
        errors++;
    endtask

    task automatic finish_test(input int id);
        string verdict;
        if (test_errors == 0) begin
            verdict = "ok";
        end else begin
            verdict = "FAIL";
        end
        $display("%s: checks=%0d errors=%0d %s", test_names[id], test_checks, test_errors,
                 verdict);
        tests_done++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic check_commit();
        int                 base;
        int                 id;
        logic               exp_flush;
        logic [`DATA_W-1:0] exp_new_pc;
        base = trace_base + 1 + 4 * trace_idx;
        id = golden[base];
        if (id != cur_test) begin
            finish_test(cur_test);
            cur_test = id;
        end
        // a redirect shows up as a break in the committed pc sequence
        exp_flush  = 1'b0;
        exp_new_pc = '0;
        if (trace_idx + 1 < trace_n) begin
            exp_new_pc = golden[base + 5];
            exp_flush  = (exp_new_pc != golden[base + 1] + 32'd4);
        end
        test_checks++;
        if (commit_pc_o !== golden[base + 1]) begin
            report_mismatch(id, "pc", golden[base + 1], commit_pc_o);
        end
        if (commit_rd_o !== golden[base + 2][4:0]) begin
            report_mismatch(id, "rd", golden[base + 2], {27'b0, commit_rd_o});
        end
        if (commit_data_o !== golden[base + 3]) begin
            report_mismatch(id, "data", golden[base + 3], commit_data_o);
        end
        if (flush_o !== exp_flush) begin
            report_mismatch(id, "flush", {31'b0, exp_flush}, {31'b0, flush_o});
        end else if (exp_flush && new_pc_o !== exp_new_pc) begin
            report_mismatch(id, "new_pc", exp_new_pc, new_pc_o);
        end
        trace_idx++;
    endtask

    // frontend model follows a redirect or steps by one word
    task automatic advance_fetch();
        int idx;
        if (front_flush) begin
            fetch_pc = front_new_pc;
        end else if (inst_valid_i) begin
            fetch_pc = fetch_pc + 32'd4;
        end
        idx = find_inst(fetch_pc);
        if (idx >= 0) begin
            inst_valid_i = 1'b1;
            pc_i         = fetch_pc;
            inst_i       = golden[2 + 2 * idx];
        end else begin
            inst_valid_i = 1'b0;
        end
    endtask

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        fetch_pc     = `RESET_PC;
        front_flush  = 1'b0;
        front_new_pc = '0;
        $readmemh("backend_golden.txt", golden);
        prog_n      = golden[0];
        trace_base  = 1 + 2 * prog_n;
        trace_n     = golden[trace_base];
        cycle_limit = trace_n * 4 + 50;
        trace_idx   = 0;
        cur_test    = 0;
        if (trace_n == 0) begin
            $display("golden file holds no commit trace");
            errors++;
        end

        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;
        advance_fetch();

        while (trace_idx < trace_n && cycles < cycle_limit) begin
            @(negedge clk);
            front_flush  = flush_o;
            front_new_pc = new_pc_o;
            if (commit_valid_o === 1'b1) begin
                check_commit();
            end
            @(posedge clk);
            #1;
            advance_fetch();
            cycles++;
        end

        if (trace_idx < trace_n) begin
            $display("timeout after %0d cycles, only %0d of %0d commits seen",
                     cycles, trace_idx, trace_n);
            errors++;
        end else begin
            finish_test(cur_test);
            // count register takes the last commit at the next edge
            @(posedge clk);
            #1;
            test_checks = 1;
            if (retire_cnt_o !== golden[trace_base + 1 + 4 * trace_n]) begin
                report_mismatch(5, "count", golden[trace_base + 1 + 4 * trace_n],
                                retire_cnt_o);
            end
            finish_test(5);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== backend_golden.txt ====
// program: entry count, then one address and instruction word per line
// trace: entry count, then test id, pc, rd, data per line; last word is the retired count
25
1c000000 02848c01 // addi.w r1, r0, 0x123
1c000004 02bff402 // addi.w r2, r0, -3
1c000008 142468a3 // lu12i.w r3, 0x12345
1c00000c 00100824 // add.w r4, r1, r2
1c000010 00110825 // sub.w r5, r1, r2
1c000014 00148866 // and r6, r3, r2
1c000018 00150c27 // or r7, r1, r3
1c00001c 00158868 // xor r8, r3, r2
1c000020 00120449 // slt r9, r2, r1
1c000024 0012082a // slt r10, r1, r2
1c000028 02801c0b // addi.w r11, r0, 7
1c00002c 00102d6c // add.w r12, r11, r11
1c000030 00112d8d // sub.w r13, r12, r11
1c000034 0015b1ab // xor r11, r13, r12
1c000038 0280416b // addi.w r11, r11, 0x10
1c00003c 00122dae // slt r14, r13, r11
1c000040 02815420 // addi.w r0, r1, 0x55
1c000044 0010040f // add.w r15, r0, r1
1c000048 00150010 // or r16, r0, r0
1c00004c 58000c2f // beq r1, r15, +12 taken
1c000050 02800411 // wrong path
1c000054 02800811 // wrong path
1c000058 5c00082f // bne r1, r15, +8 not taken
1c00005c 0280cc12 // addi.w r18, r0, 0x33
1c000060 5c000e40 // bne r18, r0, +12 taken
1c000064 02800c13 // wrong path
1c000068 02801013 // wrong path
1c00006c 50000c00 // b +12
1c000070 02801413 // wrong path
1c000074 02801813 // wrong path
1c000078 58000a40 // beq r18, r0, +8 not taken
1c00007c 00103e54 // add.w r20, r18, r15
1c000080 ffffffff // illegal
1c000084 02800415 // wrong path
1c000088 02800815 // wrong path
1c008000 02800696 // addi.w r22, r20, 1 at the exception entry
1c008004 00105ad7 // add.w r23, r22, r22
1d
0 1c000000 01 00000123
0 1c000004 02 fffffffd
0 1c000008 03 12345000
0 1c00000c 04 00000120
0 1c000010 05 00000126
0 1c000014 06 12345000
0 1c000018 07 12345123
0 1c00001c 08 edcbaffd
0 1c000020 09 00000001
0 1c000024 0a 00000000
1 1c000028 0b 00000007
1 1c00002c 0c 0000000e
1 1c000030 0d 00000007
1 1c000034 0b 00000009
1 1c000038 0b 00000019
1 1c00003c 0e 00000001
2 1c000040 00 00000178
2 1c000044 0f 00000123
2 1c000048 10 00000000
3 1c00004c 00 00000000
3 1c000058 00 00000000
3 1c00005c 12 00000033
3 1c000060 00 00000000
3 1c00006c 00 00000000
3 1c000078 00 00000000
3 1c00007c 14 00000156
4 1c000080 00 00000000
4 1c008000 16 00000157
4 1c008004 17 000002ae
1d

// ==== files.f ====
+incdir+.
backend_pkg.sv
inst_decoder.sv
reg_file.sv
exec_unit.sv
commit_ctrl.sv
backend_top.sv
backend_assert.sv
backend_tb.sv

// ==== Makefile ====
TOP := backend_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f files.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
